// ==== include/capture_consts.svh ====
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// host command bytes, ascii a through i
`define CMD_WR_ROWS       8'h61
`define CMD_WR_COLUMNS    8'h62
`define CMD_WR_ENABLE     8'h63
`define CMD_RD_ROWS       8'h64
`define CMD_RD_COLUMNS    8'h65
`define CMD_RD_ENABLE     8'h66
`define CMD_RD_CFG        8'h67
`define CMD_WR_CFG_PART   8'h68
`define CMD_WR_CFG_ALL    8'h69

// csi receiver register word addresses
`define REG_ADDR_ENABLE   6'd0
`define REG_ADDR_ROWS     6'd1
`define REG_ADDR_COLUMNS  6'd2
`define REG_ADDR_CONFIG   6'd3

// values written by the host commands
`define ROWS_VALUE        32'd1080
`define COLUMNS_VALUE     32'd1920
`define CFG_VALUE_PART    32'd2
`define CFG_VALUE_ALL     32'd3

// output fifo size in 32-bit words
`define FRAME_FIFO_DEPTH  16

`endif

// ==== hw/capture_pkg.sv ====
package capture_pkg;

	// one ascii command byte from the host
	typedef logic [7:0] cmd_byte_t;

	// word address into the csi register block
	typedef logic [5:0] reg_addr_t;

	typedef logic [31:0] reg_word_t;

	// raw10 pixel as decoded by the receiver
	typedef logic [9:0] pixel_t;

	typedef logic [31:0] fifo_word_t;

	// line start/end counters and error count
	typedef logic [3:0] line_count_t;

	typedef enum logic [3:0]
	{
		st_idle,
		st_reg_write,
		st_reg_read,
		st_read_push,
		st_wait_fs,
		st_transfer,
		st_pause_off,
		st_drain,
		st_resume_on,
		st_stop
	} ctrl_state_t;

endpackage

// ==== hw/csi_cfg_regs.sv ====
`timescale 1ns/1ps
`include "capture_consts.svh"

module csi_cfg_regs
(
	input  logic                  bus_clk,
	input  logic                  rst_n,
	input  logic                  reg_write,
	input  logic                  reg_read,
	input  capture_pkg::reg_addr_t reg_addr,
	input  capture_pkg::reg_word_t reg_wdata,
	output capture_pkg::reg_word_t reg_rdata,
	output logic                  cap_enable
);
	import capture_pkg::*;

	reg_word_t enable_reg;
	reg_word_t rows_reg;
	reg_word_t columns_reg;
	reg_word_t config_reg;

	// write port, one word per cycle
	always_ff @(posedge bus_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			enable_reg  <= '0;
			rows_reg    <= '0;
			columns_reg <= '0;
			config_reg  <= '0;
		end
		else if (reg_write)
		begin
			case (reg_addr)
				`REG_ADDR_ENABLE:  enable_reg  <= reg_wdata;
				`REG_ADDR_ROWS:    rows_reg    <= reg_wdata;
				`REG_ADDR_COLUMNS: columns_reg <= reg_wdata;
				`REG_ADDR_CONFIG:  config_reg  <= reg_wdata;
				default:           ;
			endcase
		end
	end

	// read data only changes on a read strobe, holds otherwise
	always_ff @(posedge bus_clk or negedge rst_n)
	begin
		if (!rst_n)
			reg_rdata <= '0;
		else if (reg_read)
		begin
			case (reg_addr)
				`REG_ADDR_ENABLE:  reg_rdata <= enable_reg;
				`REG_ADDR_ROWS:    reg_rdata <= rows_reg;
				`REG_ADDR_COLUMNS: reg_rdata <= columns_reg;
				`REG_ADDR_CONFIG:  reg_rdata <= config_reg;
				default:           reg_rdata <= '0;
			endcase
		end
	end

	assign cap_enable = enable_reg[0];

endmodule

// ==== hw/capture_ctrl.sv ====
`timescale 1ns/1ps
`include "capture_consts.svh"

module capture_ctrl
(
	input  logic                   bus_clk,
	input  logic                   rst_n,
	input  capture_pkg::cmd_byte_t  cmd_data,
	input  logic                   cmd_valid,
	input  capture_pkg::reg_word_t  reg_rdata,
	input  logic                   cap_enable,
	input  logic                   frame_start,
	input  logic                   frame_end,
	input  capture_pkg::pixel_t     pix_data,
	input  logic                   pix_valid,
	input  logic                   fifo_full,
	input  logic                   fifo_empty,
	output logic                   cmd_ready,
	output logic                   reg_write,
	output logic                   reg_read,
	output capture_pkg::reg_addr_t  reg_addr,
	output capture_pkg::reg_word_t  reg_wdata,
	output logic                   fifo_push,
	output capture_pkg::fifo_word_t fifo_wdata,
	output logic                   xfer_active
);
	import capture_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	ctrl_state_t dec_state;
	reg_addr_t   dec_addr;
	reg_word_t   dec_val;
	reg_addr_t   pend_addr;
	reg_word_t   pend_val;

	// command byte decode, unknown bytes fall back to idle
	always_comb
	begin
		dec_state = st_idle;
		dec_addr  = `REG_ADDR_ENABLE;
		dec_val   = '0;
		case (cmd_data)
			`CMD_WR_ROWS:
			begin
				dec_state = st_reg_write;
				dec_addr  = `REG_ADDR_ROWS;
				dec_val   = `ROWS_VALUE;
			end
			`CMD_WR_COLUMNS:
			begin
				dec_state = st_reg_write;
				dec_addr  = `REG_ADDR_COLUMNS;
				dec_val   = `COLUMNS_VALUE;
			end
			`CMD_WR_ENABLE:
			begin
				dec_state = st_reg_write;
				dec_val   = 32'd1;
			end
			`CMD_WR_CFG_PART:
			begin
				dec_state = st_reg_write;
				dec_addr  = `REG_ADDR_CONFIG;
				dec_val   = `CFG_VALUE_PART;
			end
			`CMD_WR_CFG_ALL:
			begin
				dec_state = st_reg_write;
				dec_addr  = `REG_ADDR_CONFIG;
				dec_val   = `CFG_VALUE_ALL;
			end
			`CMD_RD_ROWS:
			begin
				dec_state = st_reg_read;
				dec_addr  = `REG_ADDR_ROWS;
			end
			`CMD_RD_COLUMNS:
			begin
				dec_state = st_reg_read;
				dec_addr  = `REG_ADDR_COLUMNS;
			end
			`CMD_RD_ENABLE:   dec_state = st_reg_read;
			`CMD_RD_CFG:
			begin
				dec_state = st_reg_read;
				dec_addr  = `REG_ADDR_CONFIG;
			end
			default:          dec_state = st_idle;
		endcase
	end

	always_comb
	begin
		state_next = state;
		cmd_ready  = 1'b0;
		reg_write  = 1'b0;
		reg_read   = 1'b0;
		reg_addr   = pend_addr;
		reg_wdata  = pend_val;
		fifo_push  = 1'b0;
		fifo_wdata = reg_rdata;
		case (state)
			st_idle:
			begin
				cmd_ready = 1'b1;
				if (cmd_valid)
					state_next = dec_state;
			end
			st_reg_write:
			begin
				reg_write = 1'b1;
				// the enable command arms the capture
				if (pend_addr == `REG_ADDR_ENABLE)
					state_next = st_wait_fs;
				else
					state_next = st_idle;
			end
			st_reg_read:
			begin
				reg_read   = 1'b1;
				state_next = st_read_push;
			end
			st_read_push:
			begin
				// hold the registered word until there is room
				if (!fifo_full)
				begin
					fifo_push  = 1'b1;
					state_next = st_idle;
				end
			end
			st_wait_fs:
			begin
				if (frame_start)
					state_next = st_transfer;
			end
			st_transfer:
			begin
				fifo_wdata = fifo_word_t'(pix_data);
				if (frame_end)
					state_next = st_stop;
				else if (fifo_full)
					state_next = st_pause_off;
				else
					fifo_push = pix_valid && cap_enable;
			end
			st_pause_off:
			begin
				reg_write  = 1'b1;
				reg_addr   = `REG_ADDR_ENABLE;
				reg_wdata  = '0;
				state_next = frame_end ? st_stop : st_drain;
			end
			st_drain:
			begin
				if (frame_end)
					state_next = st_stop;
				else if (fifo_empty)
					state_next = st_resume_on;
			end
			st_resume_on:
			begin
				reg_write  = 1'b1;
				reg_addr   = `REG_ADDR_ENABLE;
				reg_wdata  = 32'd1;
				state_next = frame_end ? st_stop : st_transfer;
			end
			st_stop:
			begin
				reg_write  = 1'b1;
				reg_addr   = `REG_ADDR_ENABLE;
				reg_wdata  = '0;
				state_next = st_idle;
			end
			default:      state_next = st_idle;
		endcase
	end

	always_ff @(posedge bus_clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= state_next;
	end

	// address and value of the accepted command
	always_ff @(posedge bus_clk)
	begin
		if (state == st_idle && cmd_valid)
		begin
			pend_addr <= dec_addr;
			pend_val  <= dec_val;
		end
	end

	assign xfer_active = (state == st_transfer);

endmodule

// ==== hw/frame_fifo.sv ====
`timescale 1ns/1ps
`include "capture_consts.svh"

module frame_fifo
#(
	parameter int depth = `FRAME_FIFO_DEPTH
)
(
	input  logic                   bus_clk,
	input  logic                   rst_n,
	input  logic                   push,
	input  capture_pkg::fifo_word_t wdata,
	input  logic                   pop,
	output capture_pkg::fifo_word_t rdata,
	output logic                   full,
	output logic                   empty
);
	import capture_pkg::*;

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	fifo_word_t      mem [depth];
	logic [aw-1:0]   wr_ptr;
	logic [aw-1:0]   rd_ptr;
	logic [cw-1:0]   count;
	logic            do_push;
	logic            do_pop;

	// overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge bus_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// storage and the non show-ahead output register
	always_ff @(posedge bus_clk)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
		if (do_pop)
			rdata <= mem[rd_ptr];
	end

	assign full  = (count == cw'(depth));
	assign empty = (count == '0);

endmodule

// ==== hw/line_check.sv ====
`timescale 1ns/1ps

module line_check
(
	input  logic                    bus_clk,
	input  logic                    rst_n,
	input  logic                    xfer_active,
	input  logic                    line_start,
	input  logic                    line_end,
	output capture_pkg::line_count_t err_count
);
	import capture_pkg::*;

	line_count_t ls_count;
	line_count_t le_count;

	// a start while the counts differ means the last line never ended
	always_ff @(posedge bus_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ls_count  <= '0;
			le_count  <= '0;
			err_count <= '0;
		end
		else if (xfer_active)
		begin
			if (line_start)
			begin
				ls_count <= ls_count + 1'b1;
				if (ls_count != le_count)
					err_count <= err_count + 1'b1;
			end
			if (line_end)
				le_count <= le_count + 1'b1;
		end
	end

endmodule

// ==== hw/camera_capture_top.sv ====
`timescale 1ns/1ps
`include "capture_consts.svh"

module camera_capture_top
(
	input  logic                    bus_clk,
	input  logic                    rst_n,
	input  capture_pkg::cmd_byte_t   cmd_data,
	input  logic                    cmd_valid,
	output logic                    cmd_ready,
	input  capture_pkg::pixel_t      pix_data,
	input  logic                    pix_valid,
	input  logic                    frame_start,
	input  logic                    frame_end,
	input  logic                    line_start,
	input  logic                    line_end,
	input  logic                    out_rden,
	output capture_pkg::fifo_word_t  out_data,
	output logic                    out_empty,
	output capture_pkg::line_count_t line_err_count
);
	import capture_pkg::*;

	logic       reg_write;
	logic       reg_read;
	reg_addr_t  reg_addr;
	reg_word_t  reg_wdata;
	reg_word_t  reg_rdata;
	logic       cap_enable;
	logic       fifo_push;
	fifo_word_t fifo_wdata;
	logic       fifo_full;
	logic       xfer_active;

	capture_ctrl u_ctrl
	(
		.bus_clk     (bus_clk),
		.rst_n       (rst_n),
		.cmd_data    (cmd_data),
		.cmd_valid   (cmd_valid),
		.reg_rdata   (reg_rdata),
		.cap_enable  (cap_enable),
		.frame_start (frame_start),
		.frame_end   (frame_end),
		.pix_data    (pix_data),
		.pix_valid   (pix_valid),
		.fifo_full   (fifo_full),
		.fifo_empty  (out_empty),
		.cmd_ready   (cmd_ready),
		.reg_write   (reg_write),
		.reg_read    (reg_read),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.fifo_push   (fifo_push),
		.fifo_wdata  (fifo_wdata),
		.xfer_active (xfer_active)
	);

	csi_cfg_regs u_regs
	(
		.bus_clk    (bus_clk),
		.rst_n      (rst_n),
		.reg_write  (reg_write),
		.reg_read   (reg_read),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.cap_enable (cap_enable)
	);

	// host drains this one directly
	frame_fifo #(.depth(`FRAME_FIFO_DEPTH)) u_fifo
	(
		.bus_clk (bus_clk),
		.rst_n   (rst_n),
		.push    (fifo_push),
		.wdata   (fifo_wdata),
		.pop     (out_rden),
		.rdata   (out_data),
		.full    (fifo_full),
		.empty   (out_empty)
	);

	line_check u_line
	(
		.bus_clk     (bus_clk),
		.rst_n       (rst_n),
		.xfer_active (xfer_active),
		.line_start  (line_start),
		.line_end    (line_end),
		.err_count   (line_err_count)
	);

endmodule

// ==== test/tb_camera_capture.sv ====
`timescale 1ns/1ps
`include "capture_consts.svh"

module tb_camera_capture;
	import capture_pkg::*;

	localparam int wait_limit = 200;

	logic        bus_clk;
	logic        rst_n;
	cmd_byte_t   cmd_data;
	logic        cmd_valid;
	logic        cmd_ready;
	pixel_t      pix_data;
	logic        pix_valid;
	logic        frame_start;
	logic        frame_end;
	logic        line_start;
	logic        line_end;
	logic        out_rden;
	fifo_word_t  out_data;
	logic        out_empty;
	line_count_t line_err_count;

	string       test_name;
	logic [31:0] rng_state;
	// pixels pushed by the testbench, in the order they should come out
	fifo_word_t  expected_q[$];

	camera_capture_top DUT
	(
		.bus_clk        (bus_clk),
		.rst_n          (rst_n),
		.cmd_data       (cmd_data),
		.cmd_valid      (cmd_valid),
		.cmd_ready      (cmd_ready),
		.pix_data       (pix_data),
		.pix_valid      (pix_valid),
		.frame_start    (frame_start),
		.frame_end      (frame_end),
		.line_start     (line_start),
		.line_end       (line_end),
		.out_rden       (out_rden),
		.out_data       (out_data),
		.out_empty      (out_empty),
		.line_err_count (line_err_count)
	);

	initial
	begin
		bus_clk = 1'b0;
		forever #2 bus_clk = ~bus_clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge bus_clk);
		#1;
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_word(input fifo_word_t expected, input fifo_word_t actual);
		if (actual !== expected)
			stop_with_error($sformatf("mismatch in %s: expected 0x%08h, actual 0x%08h",
				test_name, expected, actual));
	endtask

	task automatic check_count(input line_count_t expected, input line_count_t actual);
		if (actual !== expected)
			stop_with_error($sformatf("mismatch in %s: expected %0d, actual %0d",
				test_name, expected, actual));
	endtask

	task automatic check_flag(input logic expected, input logic actual);
		if (actual !== expected)
			stop_with_error($sformatf("mismatch in %s: expected %b, actual %b",
				test_name, expected, actual));
	endtask

	task automatic wait_cmd_ready();
		int waited;
		waited = 0;
		while (cmd_ready !== 1'b1)
		begin
			next_cycle();
			waited++;
			if (waited > wait_limit)
				stop_with_error($sformatf("cmd_ready never went high in %s", test_name));
		end
	endtask

	task automatic send_cmd(input cmd_byte_t code);
		wait_cmd_ready();
		cmd_data  = code;
		cmd_valid = 1'b1;
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic pop_word(output fifo_word_t word);
		int waited;
		waited = 0;
		while (out_empty !== 1'b0)
		begin
			next_cycle();
			waited++;
			if (waited > wait_limit)
				stop_with_error($sformatf("output fifo stayed empty in %s", test_name));
		end
		out_rden = 1'b1;
		next_cycle();
		out_rden = 1'b0;
		word = out_data;
	endtask

	task automatic read_reg(input cmd_byte_t code, input fifo_word_t expected);
		fifo_word_t word;
		send_cmd(code);
		pop_word(word);
		check_word(expected, word);
	endtask

	// pop n words, compare them in order, then nothing may be left
	task automatic drain_and_compare(input int n);
		fifo_word_t word;
		for (int i = 0; i < n; i++)
		begin
			pop_word(word);
			check_word(expected_q.pop_front(), word);
		end
		check_flag(1'b1, out_empty);
	endtask

	task automatic drive_pixel();
		rng_state = xorshift32(rng_state);
		pix_data  = rng_state[9:0];
		pix_valid = 1'b1;
		expected_q.push_back({22'd0, rng_state[9:0]});
		next_cycle();
		pix_valid = 1'b0;
	endtask

	// enable write lands one edge after acceptance, then frame start
	task automatic start_frame();
		send_cmd(`CMD_WR_ENABLE);
		next_cycle();
		frame_start = 1'b1;
		next_cycle();
		frame_start = 1'b0;
	endtask

	task automatic end_frame();
		frame_end = 1'b1;
		next_cycle();
		frame_end = 1'b0;
	endtask

	task automatic strobe_line(input logic is_start);
		line_start = is_start;
		line_end   = !is_start;
		next_cycle();
		line_start = 1'b0;
		line_end   = 1'b0;
	endtask

	task automatic test_reset();
		test_name = "reset";
		check_flag(1'b1, out_empty);
		check_flag(1'b1, cmd_ready);
		check_count(4'd0, line_err_count);
		read_reg(`CMD_RD_ENABLE, 32'd0);
	endtask

	task automatic test_rows_columns();
		test_name = "rows_columns";
		send_cmd(`CMD_WR_ROWS);
		read_reg(`CMD_RD_ROWS, 32'd1080);
		send_cmd(`CMD_WR_COLUMNS);
		read_reg(`CMD_RD_COLUMNS, 32'd1920);
		// a read would push within 4 cycles, so an unknown byte must leave it empty
		send_cmd(8'h7a);
		repeat (4) next_cycle();
		check_flag(1'b1, out_empty);
		check_flag(1'b1, cmd_ready);
	endtask

	task automatic test_config();
		test_name = "config";
		send_cmd(`CMD_WR_CFG_PART);
		read_reg(`CMD_RD_CFG, 32'd2);
		send_cmd(`CMD_WR_CFG_ALL);
		read_reg(`CMD_RD_CFG, 32'd3);
	endtask

	task automatic test_frame_capture();
		test_name = "frame_capture";
		start_frame();
		for (int i = 0; i < 10; i++)
		begin
			drive_pixel();
			if (i % 2 == 1)
				next_cycle();
		end
		end_frame();
		drain_and_compare(10);
		read_reg(`CMD_RD_ENABLE, 32'd0);
	endtask

	task automatic test_back_pressure();
		test_name = "back_pressure";
		start_frame();
		repeat (16) drive_pixel();
		// controller is pausing on full and must not take commands
		repeat (4)
		begin
			check_flag(1'b0, cmd_ready);
			check_flag(1'b0, out_empty);
			next_cycle();
		end
		drain_and_compare(16);
		// drain seen, enable written back, transfer running again
		repeat (3) next_cycle();
		repeat (5) drive_pixel();
		end_frame();
		drain_and_compare(5);
	endtask

	task automatic test_line_check();
		test_name = "line_check";
		start_frame();
		strobe_line(1'b1);
		strobe_line(1'b0);
		strobe_line(1'b1);
		strobe_line(1'b0);
		strobe_line(1'b1);
		strobe_line(1'b1);
		strobe_line(1'b0);
		end_frame();
		wait_cmd_ready();
		check_count(4'd1, line_err_count);
		check_flag(1'b1, out_empty);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		cmd_data    = '0;
		cmd_valid   = 1'b0;
		pix_data    = '0;
		pix_valid   = 1'b0;
		frame_start = 1'b0;
		frame_end   = 1'b0;
		line_start  = 1'b0;
		line_end    = 1'b0;
		out_rden    = 1'b0;
		rng_state   = 32'hde45;
		test_name   = "setup";
		repeat (4) @(posedge bus_clk);
		#1;
		rst_n = 1'b1;
		next_cycle();

		test_reset();
		test_rows_columns();
		test_config();
		test_frame_capture();
		test_back_pressure();
		test_line_check();

		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
hw/capture_pkg.sv
hw/csi_cfg_regs.sv
hw/capture_ctrl.sv
hw/frame_fifo.sv
hw/line_check.sv
hw/camera_capture_top.sv
test/tb_camera_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -Wno-fatal -f sources.f --top-module tb_camera_capture -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1

grep -q "TB PASSED" sim.log \
	&& echo "simulation passed, see sim.log" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
